/* Makefile */
TOP = tb_rvv_backend

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* build.f */
rvv_lite_pkg.sv
rvv_ifs.sv
cmd_fifo.sv
rvv_dispatch_ctrl.sv
rvv_alu.sv
rvv_rob.sv
rvv_vrf.sv
rvv_backend_lite.sv
tb_rvv_backend.sv

/* cmd_fifo.sv */
module cmd_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  T     din,
    input  logic pop,
    output T     dout,
    output logic full,
    output logic empty
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    T     mem [DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic do_push;
    logic do_pop;

    assign full    = (count == cnt_t'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr_t'(wr_ptr + 1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr_t'(rd_ptr + 1);
            end
            count <= cnt_t'(count + cnt_t'(do_push) - cnt_t'(do_pop));
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

/* rvv_alu.sv */
module rvv_alu import rvv_lite_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rs_entry_t               rs_head,
    input  logic                    rs_empty,
    output logic                    rs_pop,
    output logic                    wb_valid,
    output logic [ROB_TAG_W-1:0]    wb_tag,
    output vreg_t                   wb_data
);

    vreg_t alu_res;

    assign rs_pop = !rs_empty;

    // Element-wise, wraps modulo 256
    always_comb begin
        alu_res = '0;
        for (int i = 0; i < NUM_ELEM; i++) begin
            case (rs_head.op)
                OP_VADD_VV, OP_VADD_VX: alu_res[i*SEW +: SEW] =
                    rs_head.opnd_a[i*SEW +: SEW] + rs_head.opnd_b[i*SEW +: SEW];
                OP_VSUB_VV: alu_res[i*SEW +: SEW] =
                    rs_head.opnd_a[i*SEW +: SEW] - rs_head.opnd_b[i*SEW +: SEW];
                OP_VAND_VV: alu_res[i*SEW +: SEW] =
                    rs_head.opnd_a[i*SEW +: SEW] & rs_head.opnd_b[i*SEW +: SEW];
                OP_VOR_VV: alu_res[i*SEW +: SEW] =
                    rs_head.opnd_a[i*SEW +: SEW] | rs_head.opnd_b[i*SEW +: SEW];
                default: alu_res[i*SEW +: SEW] = rs_head.opnd_b[i*SEW +: SEW];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= !rs_empty;
        end
    end

    always_ff @(posedge clk) begin
        if (!rs_empty) begin
            wb_tag  <= rs_head.tag;
            wb_data <= alu_res;
        end
    end

endmodule

/* rvv_backend_lite.sv */
module rvv_backend_lite import rvv_lite_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_valid,
    input  vec_op_e                 cmd_op,
    input  logic [VREG_IDX_W-1:0]   cmd_vd,
    input  logic [VREG_IDX_W-1:0]   cmd_vs1,
    input  logic [VREG_IDX_W-1:0]   cmd_vs2,
    input  logic [XLEN-1:0]         cmd_scalar,
    output logic                    cmd_ready,
    output logic                    rt_valid,
    output logic [VREG_IDX_W-1:0]   rt_vd,
    output vreg_t                   rt_data
);

    rvv_cmd_t               cmd_in;
    rvv_cmd_t               cq_head;
    logic                   cq_full;
    logic                   cq_empty;
    logic                   cq_pop;
    rs_entry_t              rs_entry;
    rs_entry_t              rs_head;
    logic                   rs_push;
    logic                   rs_pop;
    logic                   rs_full;
    logic                   rs_empty;
    logic                   wb_valid;
    logic [ROB_TAG_W-1:0]   wb_tag;
    vreg_t                  wb_data;

    rob_alloc_if rob_if ();
    vrf_rd_if    vrf_if ();

    assign cmd_in = '{
        op:     cmd_op,
        vd:     cmd_vd,
        vs1:    cmd_vs1,
        vs2:    cmd_vs2,
        scalar: cmd_scalar
    };
    assign cmd_ready = !cq_full;

    cmd_fifo #(.T(rvv_cmd_t), .DEPTH(CQ_DEPTH)) u_cmd_queue (
        .clk(clk), .rst_n(rst_n),
        .push(cmd_valid && cmd_ready), .din(cmd_in),
        .pop(cq_pop), .dout(cq_head),
        .full(cq_full), .empty(cq_empty)
    );

    rvv_dispatch_ctrl u_dispatch (
        .clk(clk), .rst_n(rst_n),
        .cq_head(cq_head), .cq_empty(cq_empty), .cq_pop(cq_pop),
        .rob(rob_if.ctrl), .vrf(vrf_if.ctrl),
        .rs_push(rs_push), .rs_entry(rs_entry), .rs_full(rs_full)
    );

    cmd_fifo #(.T(rs_entry_t), .DEPTH(RS_DEPTH)) u_alu_rs (
        .clk(clk), .rst_n(rst_n),
        .push(rs_push), .din(rs_entry),
        .pop(rs_pop), .dout(rs_head),
        .full(rs_full), .empty(rs_empty)
    );

    rvv_alu u_alu (
        .clk(clk), .rst_n(rst_n),
        .rs_head(rs_head), .rs_empty(rs_empty), .rs_pop(rs_pop),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_data(wb_data)
    );

    rvv_rob u_rob (
        .clk(clk), .rst_n(rst_n), .alloc(rob_if.rob),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_data(wb_data),
        .rt_valid(rt_valid), .rt_vd(rt_vd), .rt_data(rt_data)
    );

    // Retirement writes the register file directly
    rvv_vrf u_vrf (
        .clk(clk), .rst_n(rst_n), .rd(vrf_if.vrf),
        .wr_en(rt_valid), .wr_idx(rt_vd), .wr_data(rt_data)
    );

endmodule

/* rvv_dispatch_ctrl.sv */
module rvv_dispatch_ctrl import rvv_lite_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  rvv_cmd_t        cq_head,
    input  logic            cq_empty,
    output logic            cq_pop,
    rob_alloc_if.ctrl       rob,
    vrf_rd_if.ctrl          vrf,
    output logic            rs_push,
    output rs_entry_t       rs_entry,
    input  logic            rs_full
);

    logic reads_vs1;
    logic reads_vs2;
    logic scalar_form;
    logic raw_hazard;
    logic dispatch;

    // Source usage per opcode
    always_comb begin
        reads_vs1   = 1'b0;
        reads_vs2   = 1'b0;
        scalar_form = 1'b0;
        case (cq_head.op)
            OP_VADD_VV, OP_VSUB_VV, OP_VAND_VV, OP_VOR_VV: begin
                reads_vs1 = 1'b1;
                reads_vs2 = 1'b1;
            end
            OP_VADD_VX: begin
                reads_vs2   = 1'b1;
                scalar_form = 1'b1;
            end
            default: scalar_form = 1'b1;
        endcase
    end

    assign raw_hazard = (reads_vs1 && rob.vd_busy[cq_head.vs1]) ||
                        (reads_vs2 && rob.vd_busy[cq_head.vs2]);

    assign dispatch = !cq_empty && !rob.rob_full && !rs_full && !raw_hazard;

    assign cq_pop          = dispatch;
    assign rob.alloc_valid = dispatch;
    assign rob.alloc_vd    = cq_head.vd;
    assign rs_push         = dispatch;

    // Port a reads vs2, port b reads vs1
    assign vrf.rd_idx_a = cq_head.vs2;
    assign vrf.rd_idx_b = cq_head.vs1;

    assign rs_entry.op     = cq_head.op;
    assign rs_entry.tag    = rob.alloc_tag;
    assign rs_entry.opnd_a = vrf.rd_data_a;
    assign rs_entry.opnd_b = scalar_form ? {NUM_ELEM{cq_head.scalar[SEW-1:0]}}
                                         : vrf.rd_data_b;

endmodule

/* rvv_ifs.sv */
interface rob_alloc_if import rvv_lite_pkg::*; ();

    logic                   alloc_valid;
    logic [VREG_IDX_W-1:0]  alloc_vd;
    logic [ROB_TAG_W-1:0]   alloc_tag;
    logic                   rob_full;
    // One bit per destination still owned by an unretired entry
    logic [NUM_VREG-1:0]    vd_busy;

    modport ctrl (output alloc_valid, alloc_vd, input alloc_tag, rob_full, vd_busy);
    modport rob  (input alloc_valid, alloc_vd, output alloc_tag, rob_full, vd_busy);

endinterface

interface vrf_rd_if import rvv_lite_pkg::*; ();

    logic [VREG_IDX_W-1:0]  rd_idx_a;
    logic [VREG_IDX_W-1:0]  rd_idx_b;
    vreg_t                  rd_data_a;
    vreg_t                  rd_data_b;

    modport ctrl (output rd_idx_a, rd_idx_b, input rd_data_a, rd_data_b);
    modport vrf  (input rd_idx_a, rd_idx_b, output rd_data_a, rd_data_b);

endinterface

/* rvv_lite_pkg.sv */
package rvv_lite_pkg;

    localparam int VLEN       = 128;
    localparam int SEW        = 8;
    localparam int NUM_ELEM   = VLEN / SEW;
    localparam int NUM_VREG   = 32;
    localparam int VREG_IDX_W = 5;
    localparam int XLEN       = 32;

    // Queue depths
    localparam int CQ_DEPTH   = 4;
    localparam int RS_DEPTH   = 4;
    localparam int ROB_DEPTH  = 8;
    localparam int ROB_TAG_W  = 3;

    typedef enum logic [2:0] {
        OP_VADD_VV = 3'd0,
        OP_VSUB_VV = 3'd1,
        OP_VAND_VV = 3'd2,
        OP_VOR_VV  = 3'd3,
        OP_VADD_VX = 3'd4,
        OP_VMV_VX  = 3'd5
    } vec_op_e;

    typedef logic [VLEN-1:0] vreg_t;

    typedef struct packed {
        vec_op_e                op;
        logic [VREG_IDX_W-1:0]  vd;
        logic [VREG_IDX_W-1:0]  vs1;
        logic [VREG_IDX_W-1:0]  vs2;
        logic [XLEN-1:0]        scalar;
    } rvv_cmd_t;

    // opnd_a is vs2, opnd_b is vs1 or the replicated scalar byte
    typedef struct packed {
        vec_op_e                op;
        logic [ROB_TAG_W-1:0]   tag;
        vreg_t                  opnd_a;
        vreg_t                  opnd_b;
    } rs_entry_t;

endpackage

/* rvv_rob.sv */
module rvv_rob import rvv_lite_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    rob_alloc_if.rob                alloc,
    input  logic                    wb_valid,
    input  logic [ROB_TAG_W-1:0]    wb_tag,
    input  vreg_t                   wb_data,
    output logic                    rt_valid,
    output logic [VREG_IDX_W-1:0]   rt_vd,
    output vreg_t                   rt_data
);

    logic [ROB_DEPTH-1:0]   valid_q;
    logic [ROB_DEPTH-1:0]   done_q;
    logic [VREG_IDX_W-1:0]  vd_q [ROB_DEPTH];
    vreg_t                  data_q [ROB_DEPTH];
    logic [ROB_TAG_W-1:0]   head;
    logic [ROB_TAG_W-1:0]   tail;
    logic [ROB_TAG_W:0]     count;

    assign alloc.alloc_tag = tail;
    assign alloc.rob_full  = (count == (ROB_TAG_W+1)'(ROB_DEPTH));

    // Head retires once its result has landed
    assign rt_valid = valid_q[head] && done_q[head];
    assign rt_vd    = vd_q[head];
    assign rt_data  = data_q[head];

    always_comb begin
        alloc.vd_busy = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (valid_q[i]) begin
                alloc.vd_busy[vd_q[i]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            done_q  <= '0;
            head    <= '0;
            tail    <= '0;
            count   <= '0;
        end else begin
            if (alloc.alloc_valid) begin
                valid_q[tail] <= 1'b1;
                done_q[tail]  <= 1'b0;
                tail          <= ROB_TAG_W'(tail + 1);
            end
            if (wb_valid) begin
                done_q[wb_tag] <= 1'b1;
            end
            if (rt_valid) begin
                valid_q[head] <= 1'b0;
                done_q[head]  <= 1'b0;
                head          <= ROB_TAG_W'(head + 1);
            end
            count <= (ROB_TAG_W+1)'(count + (ROB_TAG_W+1)'(alloc.alloc_valid)
                                          - (ROB_TAG_W+1)'(rt_valid));
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.alloc_valid) begin
            vd_q[tail] <= alloc.alloc_vd;
        end
        if (wb_valid) begin
            data_q[wb_tag] <= wb_data;
        end
    end

endmodule

/* rvv_vrf.sv */
module rvv_vrf import rvv_lite_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    vrf_rd_if.vrf                   rd,
    input  logic                    wr_en,
    input  logic [VREG_IDX_W-1:0]   wr_idx,
    input  vreg_t                   wr_data
);

    vreg_t regs [NUM_VREG];

    assign rd.rd_data_a = regs[rd.rd_idx_a];
    assign rd.rd_data_b = regs[rd.rd_idx_b];

    // Architectural state starts at zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

/* tb_rvv_backend.sv */
module tb_rvv_backend import rvv_lite_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_BCAST = 32;
    localparam int N_ARITH = 40;
    localparam int N_CHAIN = 24;
    localparam int N_BURST = 64;
    localparam int TIMEOUT_CYCLES = 20 * (N_BCAST + N_ARITH + N_CHAIN + N_BURST) + 200;

    logic                   clk;
    logic                   rst_n;
    logic                   cmd_valid;
    vec_op_e                cmd_op;
    logic [VREG_IDX_W-1:0]  cmd_vd;
    logic [VREG_IDX_W-1:0]  cmd_vs1;
    logic [VREG_IDX_W-1:0]  cmd_vs2;
    logic [XLEN-1:0]        cmd_scalar;
    logic                   cmd_ready;
    logic                   rt_valid;
    logic [VREG_IDX_W-1:0]  rt_vd;
    vreg_t                  rt_data;

    // Reference model state
    vreg_t                  shadow [NUM_VREG];
    logic [VREG_IDX_W-1:0]  exp_vd [256];
    vreg_t                  exp_data [256];
    logic [7:0]             exp_wr;
    logic [7:0]             exp_rd;
    logic [31:0]            rng_state;
    int                     err_cnt;
    int                     acc_cnt;
    int                     rt_cnt;
    int                     cycle;

    rvv_backend_lite u_dut (
        .clk(clk), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_vd(cmd_vd),
        .cmd_vs1(cmd_vs1), .cmd_vs2(cmd_vs2), .cmd_scalar(cmd_scalar),
        .cmd_ready(cmd_ready),
        .rt_valid(rt_valid), .rt_vd(rt_vd), .rt_data(rt_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Element-wise rules, 8-bit wraparound
    function automatic vreg_t model_result(input vec_op_e op, input vreg_t a, input vreg_t b,
                                           input logic [31:0] scalar);
        vreg_t      r;
        logic [7:0] x;
        logic [7:0] y;
        r = '0;
        for (int i = 0; i < NUM_ELEM; i++) begin
            x = a[i*SEW +: SEW];
            y = (op == OP_VADD_VX || op == OP_VMV_VX) ? scalar[7:0] : b[i*SEW +: SEW];
            case (op)
                OP_VADD_VV, OP_VADD_VX: r[i*SEW +: SEW] = x + y;
                OP_VSUB_VV: r[i*SEW +: SEW] = x - y;
                OP_VAND_VV: r[i*SEW +: SEW] = x & y;
                OP_VOR_VV:  r[i*SEW +: SEW] = x | y;
                default:    r[i*SEW +: SEW] = y;
            endcase
        end
        return r;
    endfunction

    // Holds the command until the queue takes it, then updates the model
    task automatic send_cmd(input vec_op_e op, input logic [4:0] vd, input logic [4:0] vs1,
                            input logic [4:0] vs2, input logic [31:0] scalar);
        vreg_t res;
        @(negedge clk);
        cmd_valid  = 1'b1;
        cmd_op     = op;
        cmd_vd     = vd;
        cmd_vs1    = vs1;
        cmd_vs2    = vs2;
        cmd_scalar = scalar;
        while (!cmd_ready) @(negedge clk);
        res = model_result(op, shadow[vs2], shadow[vs1], scalar);
        shadow[vd] = res;
        exp_vd[exp_wr]   = vd;
        exp_data[exp_wr] = res;
        exp_wr = exp_wr + 8'd1;
        acc_cnt++;
    endtask

    task automatic wait_drain();
        @(negedge clk);
        cmd_valid = 1'b0;
        while (exp_rd != exp_wr) @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s: done, %0d errors", name, err_cnt - errs_before);
    endtask

    always @(posedge clk) begin
        if (rst_n && rt_valid) begin
            exp_rd <= exp_rd + 8'd1;
            rt_cnt <= rt_cnt + 1;
        end
    end

    a_rt_expected: assert property (@(negedge clk) disable iff (!rst_n)
        rt_valid |-> exp_rd != exp_wr)
        else begin
            $display("retirement seen with no command outstanding");
            err_cnt++;
        end

    a_rt_vd: assert property (@(negedge clk) disable iff (!rst_n)
        rt_valid && exp_rd != exp_wr |-> rt_vd == exp_vd[exp_rd])
        else begin
            $display("** Error: rt_vd = %h, expected %h", rt_vd, exp_vd[exp_rd]);
            err_cnt++;
        end

    a_rt_data: assert property (@(negedge clk) disable iff (!rst_n)
        rt_valid && exp_rd != exp_wr |-> rt_data == exp_data[exp_rd])
        else begin
            $display("** Error: rt_data = %h, expected %h", rt_data, exp_data[exp_rd]);
            err_cnt++;
        end

    initial begin
        cycle = 0;
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [4:0]  prev;
        int          errs;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = OP_VADD_VV;
        cmd_vd     = '0;
        cmd_vs1    = '0;
        cmd_vs2    = '0;
        cmd_scalar = '0;
        rng_state  = 32'h46ee_35c7;
        exp_wr     = '0;
        exp_rd     = '0;
        err_cnt    = 0;
        acc_cnt    = 0;
        rt_cnt     = 0;
        for (int i = 0; i < NUM_VREG; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        errs = err_cnt;
        repeat (8) begin
            @(negedge clk);
            assert (!rt_valid) else begin
                $display("** Error: rt_valid = %h, expected 0", rt_valid);
                err_cnt++;
            end
            assert (cmd_ready) else begin
                $display("** Error: cmd_ready = %h, expected 1", cmd_ready);
                err_cnt++;
            end
        end
        report_test("reset", errs);

        errs = err_cnt;
        for (int i = 0; i < N_BCAST; i++) begin
            r = next_rand();
            send_cmd(OP_VMV_VX, 5'(i), r[9:5], r[14:10], r);
        end
        wait_drain();
        report_test("scalar broadcast", errs);

        // Sources in v0..v15, destinations in v16..v31
        errs = err_cnt;
        for (int i = 0; i < N_ARITH; i++) begin
            r = next_rand();
            send_cmd(vec_op_e'(3'(r[31:24] % 8'd5)), {1'b1, r[3:0]}, {1'b0, r[11:8]},
                     {1'b0, r[19:16]}, r);
        end
        wait_drain();
        report_test("arithmetic and logic", errs);

        errs = err_cnt;
        r = next_rand();
        prev = r[4:0];
        for (int i = 0; i < N_CHAIN; i++) begin
            r = next_rand();
            send_cmd(vec_op_e'(3'(r[31:24] % 8'd5)), r[4:0], prev, prev, r);
            prev = r[4:0];
        end
        wait_drain();
        report_test("dependent chains", errs);

        errs = err_cnt;
        for (int i = 0; i < N_BURST; i++) begin
            r = next_rand();
            send_cmd(vec_op_e'(3'(r[31:24] % 8'd6)), r[4:0], r[9:5], r[14:10], r);
        end
        wait_drain();
        repeat (10) @(negedge clk);
        assert (rt_cnt == acc_cnt) else begin
            $display("retired count %0d does not match accepted count %0d", rt_cnt, acc_cnt);
            err_cnt++;
        end
        assert (exp_rd == exp_wr) else begin
            $display("expected results still outstanding at the end of the burst");
            err_cnt++;
        end
        report_test("order and back-pressure", errs);

        $display("summary: 5 tests, %0d accepted, %0d retired, %0d errors",
                 acc_cnt, rt_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
